// File: hw/rv_core_pkg.sv
// shared sizes, instruction encodings and control types of the rv32i core
// rtl and testbench files refer to every item here by its scoped name
`default_nettype none

package rv_core_pkg;

    // datapath width and register index width
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // the first fetch after reset comes from this address
    localparam logic [XLEN-1:0] RESET_PC = '0;
    // sequential instructions sit one word apart
    localparam logic [XLEN-1:0] PC_STEP  = 4;

    // data memory is a small word array inside the core
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = 6;

    // major opcodes found in bits 6 to 0 of each instruction word
    localparam logic [6:0] OPC_OP     = 7'b011_0011;
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_LUI    = 7'b011_0111;

    // branch conditions carried in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // pass_b hands operand two straight through for lui
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    // source of the value written to the destination register
    typedef enum logic {
        WB_ALU,
        WB_LOAD
    } wb_sel_t;

endpackage

`default_nettype wire

// File: hw/rv_fetch.sv
// program counter of the core
// the pc doubles as the instruction memory address and advances every clock
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          i_branch_taken,
    input  wire  [rv_core_pkg::XLEN-1:0] i_imm,
    output logic [rv_core_pkg::XLEN-1:0] o_pc,
    output logic [rv_core_pkg::XLEN-1:0] o_next_pc
);

    // a taken branch jumps relative to the current pc
    // anything else moves on to the following word
    assign o_next_pc = i_branch_taken ? o_pc + i_imm : o_pc + rv_core_pkg::PC_STEP;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_pc <= rv_core_pkg::RESET_PC;
        end else begin
            o_pc <= o_next_pc;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_decode.sv
// main decoder of the core, purely combinational
// splits the instruction word into register indices and an immediate,
// and derives the alu operation and datapath controls from the opcode
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire  [rv_core_pkg::XLEN-1:0]       i_inst,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_rs1_addr,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_rs2_addr,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_rd_addr,
    output logic [rv_core_pkg::XLEN-1:0]       o_imm,
    output rv_core_pkg::alu_op_t               o_alu_op,
    output logic                               o_use_imm,
    output logic                               o_branch,
    output logic [2:0]                         o_branch_f3,
    output logic                               o_mem_we,
    output logic                               o_rd_we,
    output rv_core_pkg::wb_sel_t               o_wb_sel
);

    logic [6:0]                   opcode;
    logic [2:0]                   funct3;
    logic                         funct7_b5;
    logic [rv_core_pkg::XLEN-1:0] imm_i;
    logic [rv_core_pkg::XLEN-1:0] imm_s;
    logic [rv_core_pkg::XLEN-1:0] imm_b;
    logic [rv_core_pkg::XLEN-1:0] imm_u;

    // funct3 picks the operation, alt selects sub or sra
    function automatic rv_core_pkg::alu_op_t alu_from_f3(input logic [2:0] f3, input logic alt);
        rv_core_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  op = rv_core_pkg::ALU_SLL;
            3'b010:  op = rv_core_pkg::ALU_SLT;
            3'b011:  op = rv_core_pkg::ALU_SLTU;
            3'b100:  op = rv_core_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  op = rv_core_pkg::ALU_OR;
            default: op = rv_core_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode      = i_inst[6:0];
    assign funct3      = i_inst[14:12];
    assign funct7_b5   = i_inst[30];
    assign o_rs1_addr  = i_inst[19:15];
    assign o_rs2_addr  = i_inst[24:20];
    assign o_rd_addr   = i_inst[11:7];
    assign o_branch_f3 = funct3;

    ////////////////////////////////////////////////////////////////////
    // immediate formats, every one sign extended from bit 31
    ////////////////////////////////////////////////////////////////////
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};

    always_comb begin
        // an unknown opcode falls through with no register or memory write
        o_imm     = '0;
        o_alu_op  = rv_core_pkg::ALU_ADD;
        o_use_imm = 1'b0;
        o_branch  = 1'b0;
        o_mem_we  = 1'b0;
        o_rd_we   = 1'b0;
        o_wb_sel  = rv_core_pkg::WB_ALU;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                o_rd_we  = 1'b1;
                o_alu_op = alu_from_f3(funct3, funct7_b5);
            end
            rv_core_pkg::OPC_OP_IMM: begin
                // bit 30 of the immediate only means arithmetic on a right shift
                o_rd_we   = 1'b1;
                o_use_imm = 1'b1;
                o_imm     = imm_i;
                o_alu_op  = alu_from_f3(funct3, funct7_b5 && funct3 == 3'b101);
            end
            rv_core_pkg::OPC_LOAD: begin
                o_rd_we   = 1'b1;
                o_use_imm = 1'b1;
                o_imm     = imm_i;
                o_wb_sel  = rv_core_pkg::WB_LOAD;
            end
            rv_core_pkg::OPC_STORE: begin
                o_mem_we  = 1'b1;
                o_use_imm = 1'b1;
                o_imm     = imm_s;
            end
            rv_core_pkg::OPC_BRANCH: begin
                // funct3 bit 1 marks the unsigned compares bltu and bgeu
                o_branch = 1'b1;
                o_imm    = imm_b;
                o_alu_op = funct3[1] ? rv_core_pkg::ALU_SLTU : rv_core_pkg::ALU_SLT;
            end
            rv_core_pkg::OPC_LUI: begin
                o_rd_we   = 1'b1;
                o_use_imm = 1'b1;
                o_imm     = imm_u;
                o_alu_op  = rv_core_pkg::ALU_PASS_B;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rv_regfile.sv
// integer register file with two read ports and one write port
// reads are combinational and a write lands on the rising edge
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] i_rd_addr,
    input  wire                                i_rd_we,
    input  wire  [rv_core_pkg::XLEN-1:0]       i_rd_wdata,
    output logic [rv_core_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rv_core_pkg::XLEN-1:0]       o_rs2_data
);

    // x0 has no storage so the array starts at index one
    logic [rv_core_pkg::XLEN-1:0] regs [1:2**rv_core_pkg::REG_ADDR_W-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 2**rv_core_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we && i_rd_addr != '0) begin
            regs[i_rd_addr] <= i_rd_wdata;
        end
    end

    // x0 always reads as zero whatever was written to it
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

// File: hw/rv_alu.sv
// arithmetic, logic, shift and compare unit of the core
// also resolves the branch condition that funct3 names
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  var   rv_core_pkg::alu_op_t       i_op,
    input  wire  [rv_core_pkg::XLEN-1:0]     i_op1,
    input  wire  [rv_core_pkg::XLEN-1:0]     i_op2,
    input  wire  [2:0]                       i_branch_f3,
    input  wire                              i_branch,
    output logic [rv_core_pkg::XLEN-1:0]     o_result,
    output logic                             o_branch_taken
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;
    logic       lt;
    logic       cond;

    // only the low five bits of operand two count as a shift amount
    assign shamt = i_op2[4:0];
    assign eq    = i_op1 == i_op2;
    assign lt_s  = $signed(i_op1) < $signed(i_op2);
    assign lt_u  = i_op1 < i_op2;

    always_comb begin
        case (i_op)
            rv_core_pkg::ALU_ADD:    o_result = i_op1 + i_op2;
            rv_core_pkg::ALU_SUB:    o_result = i_op1 - i_op2;
            rv_core_pkg::ALU_SLL:    o_result = i_op1 << shamt;
            rv_core_pkg::ALU_SLT:    o_result = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_s};
            rv_core_pkg::ALU_SLTU:   o_result = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_u};
            rv_core_pkg::ALU_XOR:    o_result = i_op1 ^ i_op2;
            rv_core_pkg::ALU_SRL:    o_result = i_op1 >> shamt;
            rv_core_pkg::ALU_SRA:    o_result = $signed(i_op1) >>> shamt;
            rv_core_pkg::ALU_OR:     o_result = i_op1 | i_op2;
            rv_core_pkg::ALU_AND:    o_result = i_op1 & i_op2;
            rv_core_pkg::ALU_PASS_B: o_result = i_op2;
            default:                 o_result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // branch condition
    ////////////////////////////////////////////////////////////////////

    // decode already chose slt or sltu, so signedness follows the op
    assign lt = (i_op == rv_core_pkg::ALU_SLTU) ? lt_u : lt_s;

    always_comb begin
        case (i_branch_f3)
            rv_core_pkg::F3_BEQ:  cond = eq;
            rv_core_pkg::F3_BNE:  cond = ~eq;
            rv_core_pkg::F3_BLT:  cond = lt;
            rv_core_pkg::F3_BGE:  cond = ~lt;
            rv_core_pkg::F3_BLTU: cond = lt;
            rv_core_pkg::F3_BGEU: cond = ~lt;
            default:              cond = 1'b0;
        endcase
    end

    // the compare runs on every instruction but only a branch may redirect the pc
    assign o_branch_taken = i_branch & cond;

endmodule

`default_nettype wire

// File: hw/rv_mem_writeback.sv
// data memory and writeback of the core
// holds the word memory, picks the register write value and drives the retire port
`timescale 1ns/1ps
`default_nettype none

module rv_mem_writeback (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire  [rv_core_pkg::XLEN-1:0]       i_addr,
    input  wire  [rv_core_pkg::XLEN-1:0]       i_store_data,
    input  wire                                i_mem_we,
    input  wire  [rv_core_pkg::XLEN-1:0]       i_alu_result,
    input  var   rv_core_pkg::wb_sel_t         i_wb_sel,
    input  wire  [rv_core_pkg::XLEN-1:0]       i_inst,
    input  wire  [rv_core_pkg::XLEN-1:0]       i_pc,
    input  wire  [rv_core_pkg::XLEN-1:0]       i_next_pc,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] i_rd_addr,
    input  wire                                i_rd_we,
    output logic [rv_core_pkg::XLEN-1:0]       o_rd_wdata,
    output logic                               o_retire_valid,
    output logic [rv_core_pkg::XLEN-1:0]       o_retire_inst,
    output logic [rv_core_pkg::XLEN-1:0]       o_retire_pc,
    output logic [rv_core_pkg::XLEN-1:0]       o_retire_next_pc,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_retire_rd_waddr,
    output logic [rv_core_pkg::XLEN-1:0]       o_retire_rd_wdata
);

    logic [rv_core_pkg::XLEN-1:0]        dmem [rv_core_pkg::DMEM_WORDS];
    logic [rv_core_pkg::DMEM_ADDR_W-1:0] word_idx;

    // the two byte offset bits are dropped and the upper bits wrap
    assign word_idx = i_addr[rv_core_pkg::DMEM_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (i_mem_we) begin
            dmem[word_idx] <= i_store_data;
        end
    end

    // a load sees the word combinationally in the same cycle
    assign o_rd_wdata = (i_wb_sel == rv_core_pkg::WB_LOAD) ? dmem[word_idx] : i_alu_result;

    ////////////////////////////////////////////////////////////////////
    // retire port
    ////////////////////////////////////////////////////////////////////

    // low through reset and high from the first clock edge after it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_retire_valid <= 1'b0;
        end else begin
            o_retire_valid <= 1'b1;
        end
    end

    // stores, branches and unknown opcodes report destination zero
    assign o_retire_rd_waddr = i_rd_we ? i_rd_addr : '0;
    assign o_retire_rd_wdata = o_rd_wdata;
    assign o_retire_inst     = i_inst;
    assign o_retire_pc       = i_pc;
    assign o_retire_next_pc  = i_next_pc;

endmodule

`default_nettype wire

// File: hw/rv_core.sv
// top level of the single cycle rv32i core
// instruction memory sits outside and answers in the same cycle
// one instruction retires at every rising edge once reset is released
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire                                clk,
    input  wire                                rst_n,
    output logic [rv_core_pkg::XLEN-1:0]       o_imem_raddr,
    input  wire  [rv_core_pkg::XLEN-1:0]       i_imem_rdata,
    output logic                               o_retire_valid,
    output logic [rv_core_pkg::XLEN-1:0]       o_retire_inst,
    output logic [rv_core_pkg::XLEN-1:0]       o_retire_pc,
    output logic [rv_core_pkg::XLEN-1:0]       o_retire_next_pc,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_retire_rd_waddr,
    output logic [rv_core_pkg::XLEN-1:0]       o_retire_rd_wdata
);

    logic [rv_core_pkg::XLEN-1:0]       pc;
    logic [rv_core_pkg::XLEN-1:0]       next_pc;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [rv_core_pkg::XLEN-1:0]       imm;
    rv_core_pkg::alu_op_t               alu_op;
    logic                               use_imm;
    logic                               branch;
    logic [2:0]                         branch_f3;
    logic                               mem_we;
    logic                               rd_we;
    rv_core_pkg::wb_sel_t               wb_sel;
    logic [rv_core_pkg::XLEN-1:0]       rs1_data;
    logic [rv_core_pkg::XLEN-1:0]       rs2_data;
    logic [rv_core_pkg::XLEN-1:0]       op2;
    logic [rv_core_pkg::XLEN-1:0]       alu_result;
    logic                               branch_taken;
    logic [rv_core_pkg::XLEN-1:0]       rd_wdata;

    // the fetch address is the pc itself
    assign o_imem_raddr = pc;
    // operand two is the immediate for everything but register ops and branches
    assign op2 = use_imm ? imm : rs2_data;

    ////////////////////////////////////////////////////////////////////
    // fetch, then decode, register file and alu, then memory and writeback
    ////////////////////////////////////////////////////////////////////

    rv_fetch i_rv_fetch (
        .clk(clk), .rst_n(rst_n),
        .i_branch_taken(branch_taken), .i_imm(imm),
        .o_pc(pc), .o_next_pc(next_pc)
    );

    rv_decode i_rv_decode (
        .i_inst(i_imem_rdata),
        .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rd_addr(rd_addr),
        .o_imm(imm), .o_alu_op(alu_op), .o_use_imm(use_imm),
        .o_branch(branch), .o_branch_f3(branch_f3),
        .o_mem_we(mem_we), .o_rd_we(rd_we), .o_wb_sel(wb_sel)
    );

    rv_regfile i_rv_regfile (
        .clk(clk), .rst_n(rst_n),
        .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr), .i_rd_addr(rd_addr),
        .i_rd_we(rd_we), .i_rd_wdata(rd_wdata),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    rv_alu i_rv_alu (
        .i_op(alu_op), .i_op1(rs1_data), .i_op2(op2),
        .i_branch_f3(branch_f3), .i_branch(branch),
        .o_result(alu_result), .o_branch_taken(branch_taken)
    );

    rv_mem_writeback i_rv_mem_writeback (
        .clk(clk), .rst_n(rst_n),
        .i_addr(alu_result), .i_store_data(rs2_data), .i_mem_we(mem_we),
        .i_alu_result(alu_result), .i_wb_sel(wb_sel),
        .i_inst(i_imem_rdata), .i_pc(pc), .i_next_pc(next_pc),
        .i_rd_addr(rd_addr), .i_rd_we(rd_we),
        .o_rd_wdata(rd_wdata),
        .o_retire_valid(o_retire_valid), .o_retire_inst(o_retire_inst),
        .o_retire_pc(o_retire_pc), .o_retire_next_pc(o_retire_next_pc),
        .o_retire_rd_waddr(o_retire_rd_waddr), .o_retire_rd_wdata(o_retire_rd_wdata)
    );

endmodule

`default_nettype wire

// File: include/rv_tb_program.svh
// test program builder and architectural reference model for the core testbench
// include inside the testbench module, call build_program once at time zero,
// clear the model, then step it with each retired instruction word and pc
`ifndef RV_TB_PROGRAM_SVH
`define RV_TB_PROGRAM_SVH

// instruction encoders, fields taken from the low bits of each argument
function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_core_pkg::OPC_OP};
endfunction

function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_core_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            rv_core_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(int imm, int rd);
    return {imm[19:0], rd[4:0], rv_core_pkg::OPC_LUI};
endfunction

function automatic void build_program(output logic [31:0] prog[$]);
    int ra;
    int rb;
    int addr;
    void'($urandom(32'h6f37));
    prog = {};
    // the reset pc slot executes before retire valid rises so it holds a nop
    prog.push_back(enc_i(0, 0, 0, 0, rv_core_pkg::OPC_OP_IMM));
    // random operands in x1 to x8 from lui then addi
    for (int r = 1; r <= 8; r++) begin
        prog.push_back(enc_u($urandom(), r));
        prog.push_back(enc_i($urandom(), r, 0, r, rv_core_pkg::OPC_OP_IMM));
    end
    // every register and immediate alu op, sub and sra with funct7 bit 5
    for (int f3 = 0; f3 < 8; f3++) begin
        ra = $urandom_range(8, 1);
        rb = $urandom_range(8, 1);
        prog.push_back(enc_r(0, rb, ra, f3, 9 + f3));
        if (f3 == 0 || f3 == 5) begin
            prog.push_back(enc_r(32, rb, ra, f3, 17 + f3));
        end
        addr = (f3 == 1 || f3 == 5) ? $urandom_range(31, 0) : $urandom();
        prog.push_back(enc_i(addr, ra, f3, 9 + f3, rv_core_pkg::OPC_OP_IMM));
    end
    prog.push_back(enc_i(1024 + $urandom_range(31, 0), ra, 5, 24, rv_core_pkg::OPC_OP_IMM));
    // a write to x0 is dropped and a read of x0 gives zero
    prog.push_back(enc_r(0, 2, 1, 0, 0));
    prog.push_back(enc_r(0, 3, 0, 0, 25));
    // each branch kind on equal operands and on both orders of distinct ones
    for (int f3 = 0; f3 < 8; f3++) begin
        if (f3 != 2 && f3 != 3) begin
            ra = $urandom_range(8, 1);
            rb = ra % 8 + 1;
            for (int k = 0; k < 3; k++) begin
                prog.push_back(enc_b(8, (k == 1) ? rb : ra, (k == 2) ? rb : ra, f3));
                // skipped whenever the branch above is taken
                prog.push_back(enc_i(1, 26, 0, 26, rv_core_pkg::OPC_OP_IMM));
            end
        end
    end
    // store then load back the same word
    for (int k = 1; k <= 4; k++) begin
        addr = 4 * $urandom_range(rv_core_pkg::DMEM_WORDS - 1, 0);
        prog.push_back(enc_s(addr, k, 0));
        prog.push_back(enc_i(addr, 0, 2, 26 + k, rv_core_pkg::OPC_LOAD));
    end
    // park the core on a branch to itself
    prog.push_back(enc_b(0, 0, 0, 0));
endfunction

// architectural state of the reference model, apart from the pc
logic [31:0] model_regs [32];
logic [31:0] model_mem [rv_core_pkg::DMEM_WORDS];

// every register starts at zero like the core after reset
function automatic void clear_model();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
endfunction

// executes one instruction and reports what the core should retire
function automatic void step_model(input logic [31:0] inst, input logic [31:0] pc,
                                   output logic [4:0] rd, output logic [31:0] wdata,
                                   output logic [31:0] next_pc);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [2:0]  f3;
    logic        alt;
    logic        taken;
    a       = model_regs[inst[19:15]];
    b       = model_regs[inst[24:20]];
    f3      = inst[14:12];
    alt     = inst[30];
    rd      = inst[11:7];
    wdata   = '0;
    next_pc = pc + 4;
    taken   = 1'b0;
    if (inst[6:0] == rv_core_pkg::OPC_OP_IMM) begin
        b   = {{20{inst[31]}}, inst[31:20]};
        alt = alt && f3 == 3'd5;
    end
    addr = a + ((inst[6:0] == rv_core_pkg::OPC_STORE) ?
                {{20{inst[31]}}, inst[31:25], inst[11:7]} : {{20{inst[31]}}, inst[31:20]});
    case (inst[6:0])
        rv_core_pkg::OPC_OP, rv_core_pkg::OPC_OP_IMM: begin
            case (f3)
                3'd0: wdata = alt ? a - b : a + b;
                3'd1: wdata = a << b[4:0];
                3'd2: wdata = {31'b0, $signed(a) < $signed(b)};
                3'd3: wdata = {31'b0, a < b};
                3'd4: wdata = a ^ b;
                3'd5: begin
                    if (alt) wdata = $signed(a) >>> b[4:0];
                    else wdata = a >> b[4:0];
                end
                3'd6: wdata = a | b;
                default: wdata = a & b;
            endcase
        end
        rv_core_pkg::OPC_LUI: wdata = {inst[31:12], 12'b0};
        rv_core_pkg::OPC_LOAD: wdata = model_mem[addr[rv_core_pkg::DMEM_ADDR_W+1:2]];
        rv_core_pkg::OPC_STORE: begin
            model_mem[addr[rv_core_pkg::DMEM_ADDR_W+1:2]] = b;
            rd = '0;
        end
        rv_core_pkg::OPC_BRANCH: begin
            case (f3)
                rv_core_pkg::F3_BEQ:  taken = a == b;
                rv_core_pkg::F3_BNE:  taken = a != b;
                rv_core_pkg::F3_BLT:  taken = $signed(a) < $signed(b);
                rv_core_pkg::F3_BGE:  taken = $signed(a) >= $signed(b);
                rv_core_pkg::F3_BLTU: taken = a < b;
                rv_core_pkg::F3_BGEU: taken = a >= b;
                default:              taken = 1'b0;
            endcase
            if (taken) next_pc = pc + {{19{inst[31]}}, inst[31], inst[7],
                                       inst[30:25], inst[11:8], 1'b0};
            rd = '0;
        end
        default: rd = '0;
    endcase
    if (rd != '0) model_regs[rd] = wdata;
endfunction

`endif

// File: verif/tb_rv_core.sv
// testbench for the single cycle rv32i core
// builds a random program, runs it from reset and checks every retired
// instruction against the reference model from the included header
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int RESET_CYCLES = 16;
    localparam int IMEM_AW      = 8;
    localparam int IMEM_WORDS   = 2**IMEM_AW;

    // one entry per behavior that the run reports on
    localparam int T_RESET  = 0;
    localparam int T_ALU    = 1;
    localparam int T_LUI    = 2;
    localparam int T_BRANCH = 3;
    localparam int T_MEM    = 4;
    localparam int T_X0     = 5;
    localparam int N_TESTS  = 6;

    `include "rv_tb_program.svh"

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_rdata;
    logic [31:0] o_imem_raddr;
    logic        o_retire_valid;
    logic [31:0] o_retire_inst;
    logic [31:0] o_retire_pc;
    logic [31:0] o_retire_next_pc;
    logic [4:0]  o_retire_rd_waddr;
    logic [31:0] o_retire_rd_wdata;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] prog [$];
    int          prog_len;
    logic [31:0] park_inst;

    // the model's view of the instruction now on the retire port
    logic [31:0] model_pc;
    logic [4:0]  exp_rd;
    logic [31:0] exp_wdata;
    logic [31:0] exp_next_pc;
    logic        reset_seen;
    logic        done;

    int    checks [N_TESTS];
    int    fails [N_TESTS];
    int    cycle_count;
    int    cycle_limit;
    string test_names [N_TESTS] = '{"reset", "alu", "lui", "branch", "memory", "x0"};

    rv_core i_rv_core (
        .clk(clk), .rst_n(rst_n),
        .o_imem_raddr(o_imem_raddr), .i_imem_rdata(imem_rdata),
        .o_retire_valid(o_retire_valid), .o_retire_inst(o_retire_inst),
        .o_retire_pc(o_retire_pc), .o_retire_next_pc(o_retire_next_pc),
        .o_retire_rd_waddr(o_retire_rd_waddr), .o_retire_rd_wdata(o_retire_rd_wdata)
    );

    // instruction memory answers in the same cycle
    // addresses past the program see a branch to itself
    assign imem_rdata = ((o_imem_raddr >> 2) < 32'(prog_len)) ?
                        imem[o_imem_raddr[IMEM_AW+1:2]] : park_inst;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input int test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks[test]++;
        assert (act === exp) else begin
            fails[test]++;
            $display("FAILED %s %s: expected %h actual %h", test_names[test], what, exp, act);
        end
    endtask

    task automatic print_test_line(input int test);
        $display("test %-6s done: %0d checks, %0d failures",
                 test_names[test], checks[test], fails[test]);
    endtask

    // sorts an instruction word into the behavior it exercises
    function automatic int classify(input logic [31:0] inst);
        logic [6:0] opc;
        opc = inst[6:0];
        if (opc == rv_core_pkg::OPC_LUI) return T_LUI;
        if (opc == rv_core_pkg::OPC_BRANCH) return T_BRANCH;
        if (opc == rv_core_pkg::OPC_LOAD || opc == rv_core_pkg::OPC_STORE) return T_MEM;
        if (inst[11:7] == 5'd0 || inst[19:15] == 5'd0) return T_X0;
        if (opc == rv_core_pkg::OPC_OP && inst[24:20] == 5'd0) return T_X0;
        return T_ALU;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////////////

    // retire outputs settle well before the falling edge, so compare there
    always @(negedge clk) begin
        int          t;
        logic [31:0] inst;
        if (!rst_n) begin
            check_value(T_RESET, "retire valid in reset", 32'd0, 32'(o_retire_valid));
        end else if (!done) begin
            inst = imem[model_pc[IMEM_AW+1:2]];
            t    = classify(inst);
            step_model(inst, model_pc, exp_rd, exp_wdata, exp_next_pc);
            if (!reset_seen) begin
                // the reset slot retires with valid still low
                check_value(T_RESET, "first fetch address", rv_core_pkg::RESET_PC,
                            o_imem_raddr);
                check_value(T_RESET, "first retire pc", rv_core_pkg::RESET_PC, o_retire_pc);
                check_value(T_RESET, "first retire valid", 32'd0, 32'(o_retire_valid));
                reset_seen = 1'b1;
                print_test_line(T_RESET);
            end else begin
                check_value(t, "retire valid", 32'd1, 32'(o_retire_valid));
                check_value(t, "fetch address", model_pc, o_imem_raddr);
                check_value(t, "retire inst", inst, o_retire_inst);
                check_value(t, "retire pc", model_pc, o_retire_pc);
                check_value(t, "retire next pc", exp_next_pc, o_retire_next_pc);
                check_value(t, "retire rd", 32'(exp_rd), 32'(o_retire_rd_waddr));
                // data only matters when a register is written
                if (exp_rd != 5'd0) begin
                    check_value(t, "retire rd data", exp_wdata, o_retire_rd_wdata);
                end
            end
            // the program ends on a branch to itself
            done     = (exp_next_pc == model_pc);
            model_pc = exp_next_pc;
        end
    end

    // retire valid stays low for as long as reset is held
    assert property (@(posedge clk) !rst_n |-> !o_retire_valid) else begin
        fails[T_RESET]++;
        $display("reset: retire valid went high while rst_n was low");
    end

    // each retirement starts where the previous one said it would go
    assert property (@(posedge clk) disable iff (!rst_n)
                     o_retire_valid |=> o_retire_pc == $past(o_retire_next_pc)) else begin
        fails[T_BRANCH]++;
        $display("branch: retire pc did not follow the previous next pc");
    end

    // run limit from the program length, the reset and a margin
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the program did not reach its final branch in %0d cycles",
                     cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int total_checks;
        int total_fails;
        rst_n       = 1'b0;
        reset_seen  = 1'b0;
        done        = 1'b0;
        cycle_count = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            checks[t] = 0;
            fails[t]  = 0;
        end
        build_program(prog);
        prog_len = prog.size();
        for (int i = 0; i < prog_len; i++) begin
            imem[i] = prog[i];
        end
        park_inst   = enc_b(0, 0, 0, 0);
        cycle_limit = prog_len + RESET_CYCLES + 50;
        clear_model();
        model_pc    = rv_core_pkg::RESET_PC;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        wait (done);
        // let the pc follow check see the final retirement
        repeat (2) @(posedge clk);

        total_checks = 0;
        total_fails  = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            if (t != T_RESET) begin
                print_test_line(t);
            end
            total_checks += checks[t];
            total_fails  += fails[t];
        end
        $display("summary: %0d checks, %0d failures", total_checks, total_fails);
        if (total_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
hw/rv_core_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_mem_writeback.sv
hw/rv_core.sv
verif/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# builds the core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_rv_core -o sim_tb_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_rv_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
